/* verilog/rename_pkg.sv */
// rename stage package with register sizes, register types and source-select codes
package rename_pkg;

    //////////////////////////////////////////////////
    // sizes

    localparam int NUM_SLOTS = 4;
    localparam int ARCH_REGS = 32;
    localparam int PHYS_REGS = 80;
    localparam int ARCH_W    = 5;
    localparam int PHYS_W    = 7;

    //////////////////////////////////////////////////
    // types

    typedef logic [ARCH_W-1:0] arch_reg_t;
    typedef logic [PHYS_W-1:0] phys_reg_t;

    // slot codes pick the new register of that earlier slot
    typedef enum logic [1:0] {
        SEL_RAT   = 2'd0,
        SEL_SLOT0 = 2'd1,
        SEL_SLOT1 = 2'd2,
        SEL_SLOT2 = 2'd3
    } src_sel_e;

endpackage

/* verilog/rename_stage_if.sv */
// stage-0 slot results carried from the lookup blocks to the output stage
interface rename_stage_if import rename_pkg::*; ();

    // spec RAT lookups
    phys_reg_t prs1    [NUM_SLOTS];
    phys_reg_t prs2    [NUM_SLOTS];
    phys_reg_t old_prd [NUM_SLOTS];

    // free list allocation
    phys_reg_t prd     [NUM_SLOTS];
    logic      grant;

    // bundle dependency codes
    src_sel_e  rs1_sel [NUM_SLOTS];
    src_sel_e  rs2_sel [NUM_SLOTS];
    src_sel_e  rd_sel  [NUM_SLOTS];

    // output stage can take a bundle
    logic      ready;

    modport rat   (output prs1, prs2, old_prd, input prd, grant);

    modport alloc (output prd, grant, input ready);

    modport dep   (output rs1_sel, rs2_sel, rd_sel);

    modport stage (
        input  prs1, prs2, old_prd, prd, grant,
        input  rs1_sel, rs2_sel, rd_sel,
        output ready
    );

endinterface

/* verilog/spec_rat.sv */
// speculative register alias table, twelve read ports and four write ports
module spec_rat import rename_pkg::*; (
    input  logic      clock,
    input  logic      reset_n,
    input  arch_reg_t rs1_i      [NUM_SLOTS],
    input  arch_reg_t rs2_i      [NUM_SLOTS],
    input  arch_reg_t rd_i       [NUM_SLOTS],
    input  logic      write_rd_i [NUM_SLOTS],
    rename_stage_if.rat stage_if
);

    phys_reg_t rat_q [ARCH_REGS];

    //////////////////////////////////////////////////
    // lookups from the current table

    always_comb
    begin
        for (int s = 0; s < NUM_SLOTS; s++)
        begin
            stage_if.prs1[s]    = rat_q[rs1_i[s]];
            stage_if.prs2[s]    = rat_q[rs2_i[s]];
            stage_if.old_prd[s] = rat_q[rd_i[s]];
        end
    end

    //////////////////////////////////////////////////
    // update on grant

    // slots are walked in order so the youngest writer of a register lands last
    always_ff @(posedge clock or negedge reset_n)
    begin
        if (!reset_n)
        begin
            for (int i = 0; i < ARCH_REGS; i++)
            begin
                rat_q[i] <= phys_reg_t'(i);
            end
        end
        else if (stage_if.grant)
        begin
            for (int s = 0; s < NUM_SLOTS; s++)
            begin
                if (write_rd_i[s])
                begin
                    rat_q[rd_i[s]] <= stage_if.prd[s];
                end
            end
        end
    end

endmodule

/* verilog/free_list.sv */
// circular free list of physical registers, bundle allocation and retire release
module free_list import rename_pkg::*; #(
    parameter int FREE_DEPTH = 48,
    parameter int FIRST_FREE = 32
) (
    input  logic      clock,
    input  logic      reset_n,
    input  logic      bundle_valid_i,
    input  logic      write_rd_i        [NUM_SLOTS],
    input  phys_reg_t retire_free_i     [NUM_SLOTS],
    input  logic      retire_free_vld_i [NUM_SLOTS],
    output logic      rename_stall_o,
    rename_stage_if.alloc stage_if
);

    localparam int PTR_W  = $clog2(FREE_DEPTH);
    localparam int CNT_W  = $clog2(FREE_DEPTH + 1);
    localparam int STEP_W = $clog2(NUM_SLOTS + 1);

    typedef logic [PTR_W-1:0]  ptr_t;
    typedef logic [STEP_W-1:0] step_t;

    phys_reg_t         fifo_q [FREE_DEPTH];
    ptr_t              head_q;
    ptr_t              tail_q;
    logic [CNT_W-1:0]  count_q;

    step_t             need_cnt;
    step_t             rel_cnt;
    ptr_t              rel_idx [NUM_SLOTS];
    logic              short_cnt;

    // pointer advance with wrap, depth need not be a power of two
    function automatic ptr_t wrap_add(input ptr_t base, input step_t step);
        logic [PTR_W:0] sum;
        sum = {1'b0, base} + (PTR_W+1)'(step);
        if (sum >= (PTR_W+1)'(FREE_DEPTH))
        begin
            sum = sum - (PTR_W+1)'(FREE_DEPTH);
        end
        return PTR_W'(sum);
    endfunction

    //////////////////////////////////////////////////
    // allocation

    // flagged slots take consecutive entries from the head
    always_comb
    begin
        need_cnt = '0;
        for (int s = 0; s < NUM_SLOTS; s++)
        begin
            stage_if.prd[s] = fifo_q[wrap_add(head_q, need_cnt)];
            if (write_rd_i[s])
            begin
                need_cnt = need_cnt + step_t'(1);
            end
        end
    end

    assign short_cnt      = count_q < CNT_W'(need_cnt);
    assign rename_stall_o = bundle_valid_i && short_cnt;
    assign stage_if.grant = bundle_valid_i && stage_if.ready && !short_cnt;

    //////////////////////////////////////////////////
    // release

    always_comb
    begin
        rel_cnt = '0;
        for (int s = 0; s < NUM_SLOTS; s++)
        begin
            rel_idx[s] = wrap_add(tail_q, rel_cnt);
            if (retire_free_vld_i[s])
            begin
                rel_cnt = rel_cnt + step_t'(1);
            end
        end
    end

    always_ff @(posedge clock or negedge reset_n)
    begin
        if (!reset_n)
        begin
            for (int i = 0; i < FREE_DEPTH; i++)
            begin
                fifo_q[i] <= phys_reg_t'(FIRST_FREE + i);
            end
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= CNT_W'(FREE_DEPTH);
        end
        else
        begin
            for (int s = 0; s < NUM_SLOTS; s++)
            begin
                if (retire_free_vld_i[s])
                begin
                    fifo_q[rel_idx[s]] <= retire_free_i[s];
                end
            end
            if (stage_if.grant)
            begin
                head_q <= wrap_add(head_q, need_cnt);
            end
            tail_q  <= wrap_add(tail_q, rel_cnt);
            count_q <= count_q + CNT_W'(rel_cnt) - (stage_if.grant ? CNT_W'(need_cnt) : '0);
        end
    end

endmodule

/* verilog/dep_check.sv */
// bundle dependency check, picks the youngest earlier writer for each operand
module dep_check import rename_pkg::*; (
    input  arch_reg_t rs1_i      [NUM_SLOTS],
    input  arch_reg_t rs2_i      [NUM_SLOTS],
    input  arch_reg_t rd_i       [NUM_SLOTS],
    input  logic      write_rd_i [NUM_SLOTS],
    rename_stage_if.dep stage_if
);

    // scan older slots in order, a later match overrides an earlier one
    function automatic src_sel_e find_sel(input int slot, input arch_reg_t areg);
        src_sel_e sel;
        sel = SEL_RAT;
        for (int k = 0; k < NUM_SLOTS - 1; k++)
        begin
            if (k < slot && write_rd_i[k] && rd_i[k] == areg)
            begin
                sel = src_sel_e'(2'(k + 1));
            end
        end
        return sel;
    endfunction

    //////////////////////////////////////////////////
    // per-slot select codes

    // slot 0 has no older slot and always reads the table
    always_comb
    begin
        for (int s = 0; s < NUM_SLOTS; s++)
        begin
            stage_if.rs1_sel[s] = find_sel(s, rs1_i[s]);
            stage_if.rs2_sel[s] = find_sel(s, rs2_i[s]);
            stage_if.rd_sel[s]  = find_sel(s, rd_i[s]);
        end
    end

endmodule

/* verilog/bundle_override.sv */
// stage-1 bundle register with override of bundle-internal dependencies
module bundle_override import rename_pkg::*; (
    input  logic      clock,
    input  logic      reset_n,
    input  logic      pipe_stall_i,
    rename_stage_if.stage stage_if,
    output logic      out_valid_o,
    output phys_reg_t prs1_o    [NUM_SLOTS],
    output phys_reg_t prs2_o    [NUM_SLOTS],
    output phys_reg_t prd_o     [NUM_SLOTS],
    output phys_reg_t old_prd_o [NUM_SLOTS]
);

    logic      valid_q;
    phys_reg_t prs1_q    [NUM_SLOTS];
    phys_reg_t prs2_q    [NUM_SLOTS];
    phys_reg_t old_prd_q [NUM_SLOTS];
    phys_reg_t prd_q     [NUM_SLOTS];
    src_sel_e  rs1_sel_q [NUM_SLOTS];
    src_sel_e  rs2_sel_q [NUM_SLOTS];
    src_sel_e  rd_sel_q  [NUM_SLOTS];

    // new register of an older slot, or the table value
    function automatic phys_reg_t pick(input src_sel_e sel, input phys_reg_t rat_val);
        phys_reg_t val;
        case (sel)
            SEL_SLOT0: val = prd_q[0];
            SEL_SLOT1: val = prd_q[1];
            SEL_SLOT2: val = prd_q[2];
            default:   val = rat_val;
        endcase
        return val;
    endfunction

    assign stage_if.ready = !pipe_stall_i;

    //////////////////////////////////////////////////
    // stage 1 register

    // an idle cycle with ready high loads a bubble, a stall holds
    always_ff @(posedge clock or negedge reset_n)
    begin
        if (!reset_n)
            valid_q <= 1'b0;
        else if (stage_if.ready)
            valid_q <= stage_if.grant;
    end

    always_ff @(posedge clock)
    begin
        if (stage_if.grant)
        begin
            prs1_q    <= stage_if.prs1;
            prs2_q    <= stage_if.prs2;
            old_prd_q <= stage_if.old_prd;
            prd_q     <= stage_if.prd;
            rs1_sel_q <= stage_if.rs1_sel;
            rs2_sel_q <= stage_if.rs2_sel;
            rd_sel_q  <= stage_if.rd_sel;
        end
    end

    //////////////////////////////////////////////////
    // override muxes

    assign out_valid_o = valid_q;

    always_comb
    begin
        for (int s = 0; s < NUM_SLOTS; s++)
        begin
            prs1_o[s]    = pick(rs1_sel_q[s], prs1_q[s]);
            prs2_o[s]    = pick(rs2_sel_q[s], prs2_q[s]);
            old_prd_o[s] = pick(rd_sel_q[s], old_prd_q[s]);
            prd_o[s]     = prd_q[s];
        end
    end

endmodule

/* verilog/rename_top.sv */
// four-wide register rename stage, spec RAT, free list and bundle override
module rename_top import rename_pkg::*; #(
    parameter int FREE_DEPTH = PHYS_REGS - ARCH_REGS,
    parameter int FIRST_FREE = ARCH_REGS
) (
    input  logic      clock,
    input  logic      reset_n,

    // decode bundle
    input  logic      bundle_valid_i,
    input  arch_reg_t rs1_i             [NUM_SLOTS],
    input  arch_reg_t rs2_i             [NUM_SLOTS],
    input  arch_reg_t rd_i              [NUM_SLOTS],
    input  logic      write_rd_i        [NUM_SLOTS],

    // downstream back-pressure
    input  logic      pipe_stall_i,

    // retire release
    input  phys_reg_t retire_free_i     [NUM_SLOTS],
    input  logic      retire_free_vld_i [NUM_SLOTS],

    output logic      rename_stall_o,
    output logic      out_valid_o,
    output phys_reg_t prs1_o            [NUM_SLOTS],
    output phys_reg_t prs2_o            [NUM_SLOTS],
    output phys_reg_t prd_o             [NUM_SLOTS],
    output phys_reg_t old_prd_o         [NUM_SLOTS]
);

    rename_stage_if u_stage_if ();

    //////////////////////////////////////////////////
    // stage 0 lookups

    spec_rat u_spec_rat (
        .clock      (clock),
        .reset_n    (reset_n),
        .rs1_i      (rs1_i),
        .rs2_i      (rs2_i),
        .rd_i       (rd_i),
        .write_rd_i (write_rd_i),
        .stage_if   (u_stage_if)
    );

    free_list #(
        .FREE_DEPTH (FREE_DEPTH),
        .FIRST_FREE (FIRST_FREE)
    ) u_free_list (
        .clock             (clock),
        .reset_n           (reset_n),
        .bundle_valid_i    (bundle_valid_i),
        .write_rd_i        (write_rd_i),
        .retire_free_i     (retire_free_i),
        .retire_free_vld_i (retire_free_vld_i),
        .rename_stall_o    (rename_stall_o),
        .stage_if          (u_stage_if)
    );

    dep_check u_dep_check (
        .rs1_i      (rs1_i),
        .rs2_i      (rs2_i),
        .rd_i       (rd_i),
        .write_rd_i (write_rd_i),
        .stage_if   (u_stage_if)
    );

    //////////////////////////////////////////////////
    // stage 1

    bundle_override u_bundle_override (
        .clock        (clock),
        .reset_n      (reset_n),
        .pipe_stall_i (pipe_stall_i),
        .stage_if     (u_stage_if),
        .out_valid_o  (out_valid_o),
        .prs1_o       (prs1_o),
        .prs2_o       (prs2_o),
        .prd_o        (prd_o),
        .old_prd_o    (old_prd_o)
    );

endmodule

/* dv/rename_checker.sv */
// protocol assertions for the rename stage, bound into the top level
module rename_checker import rename_pkg::*; (
    input logic      clock,
    input logic      reset_n,
    input logic      pipe_stall_i,
    input logic      bundle_valid_i,
    input logic      rename_stall_i,
    input logic      out_valid_i,
    input phys_reg_t prs1_i    [NUM_SLOTS],
    input phys_reg_t prs2_i    [NUM_SLOTS],
    input phys_reg_t prd_i     [NUM_SLOTS],
    input phys_reg_t old_prd_i [NUM_SLOTS]
);

    logic [4*NUM_SLOTS*PHYS_W:0] out_bus;

    // all outputs in one vector
    always_comb
    begin
        out_bus    = '0;
        out_bus[0] = out_valid_i;
        for (int s = 0; s < NUM_SLOTS; s++)
        begin
            out_bus[1 + (4*s)*PHYS_W     +: PHYS_W] = prs1_i[s];
            out_bus[1 + (4*s + 1)*PHYS_W +: PHYS_W] = prs2_i[s];
            out_bus[1 + (4*s + 2)*PHYS_W +: PHYS_W] = prd_i[s];
            out_bus[1 + (4*s + 3)*PHYS_W +: PHYS_W] = old_prd_i[s];
        end
    end

    stall_holds_outputs: assert property (@(posedge clock) disable iff (!reset_n)
        pipe_stall_i |=> $stable(out_bus))
        else $error("outputs changed under pipe stall");

    no_stall_without_bundle: assert property (@(posedge clock) disable iff (!reset_n)
        !bundle_valid_i |-> !rename_stall_i)
        else $error("rename stall without a bundle");

    idle_in_reset: assert property (@(posedge clock) !reset_n |-> !out_valid_i)
        else $error("output valid during reset");

endmodule

/* dv/tb_rename.sv */
// testbench for the rename stage, replays per-cycle vectors and compares the outputs
module tb_rename import rename_pkg::*; ();

    localparam int CLK_PERIOD = 100;
    localparam int RST_CYCLES = 4;

    logic      clock;
    logic      reset_n;
    logic      bundle_valid_i;
    arch_reg_t rs1_i             [NUM_SLOTS];
    arch_reg_t rs2_i             [NUM_SLOTS];
    arch_reg_t rd_i              [NUM_SLOTS];
    logic      write_rd_i        [NUM_SLOTS];
    logic      pipe_stall_i;
    phys_reg_t retire_free_i     [NUM_SLOTS];
    logic      retire_free_vld_i [NUM_SLOTS];
    logic      rename_stall_o;
    logic      out_valid_o;
    phys_reg_t prs1_o            [NUM_SLOTS];
    phys_reg_t prs2_o            [NUM_SLOTS];
    phys_reg_t prd_o             [NUM_SLOTS];
    phys_reg_t old_prd_o         [NUM_SLOTS];

    string     vec_q [$];
    int        num_vec;

    rename_top u_dut (
        .clock             (clock),
        .reset_n           (reset_n),
        .bundle_valid_i    (bundle_valid_i),
        .rs1_i             (rs1_i),
        .rs2_i             (rs2_i),
        .rd_i              (rd_i),
        .write_rd_i        (write_rd_i),
        .pipe_stall_i      (pipe_stall_i),
        .retire_free_i     (retire_free_i),
        .retire_free_vld_i (retire_free_vld_i),
        .rename_stall_o    (rename_stall_o),
        .out_valid_o       (out_valid_o),
        .prs1_o            (prs1_o),
        .prs2_o            (prs2_o),
        .prd_o             (prd_o),
        .old_prd_o         (old_prd_o)
    );

    bind rename_top rename_checker u_checker (
        .clock            (clock),
        .reset_n          (reset_n),
        .pipe_stall_i     (pipe_stall_i),
        .bundle_valid_i   (bundle_valid_i),
        .rename_stall_i   (rename_stall_o),
        .out_valid_i      (out_valid_o),
        .prs1_i           (prs1_o),
        .prs2_i           (prs2_o),
        .prd_i            (prd_o),
        .old_prd_i        (old_prd_o)
    );

    initial
    begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    //////////////////////////////////////////////////
    // helpers

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp)
        begin
            $display("Error at time %0t: %s expected %h got %h", $time, name, exp, act);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    // slot 0 sits in the top byte, as in the vector file
    function automatic logic [31:0] pack_slots(input phys_reg_t regs [NUM_SLOTS]);
        logic [31:0] word;
        word = '0;
        for (int s = 0; s < NUM_SLOTS; s++)
        begin
            word[31 - 8*s -: 8] = {1'b0, regs[s]};
        end
        return word;
    endfunction

    task automatic run_line(input string line);
        logic [31:0] bv, wr, rs1_w, rs2_w, rd_w, ps, rv, rel_w;
        logic [31:0] exp_stall, exp_valid, exp_prs1, exp_prs2, exp_prd, exp_old;
        int          n;
        n = $sscanf(line, "%h %b %h %h %h %h %b %h %h %h %h %h %h %h",
                    bv, wr, rs1_w, rs2_w, rd_w, ps, rv, rel_w,
                    exp_stall, exp_valid, exp_prs1, exp_prs2, exp_prd, exp_old);
        if (n != 14)
        begin
            $display("a vector line could not be parsed: %s", line);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
        bundle_valid_i = bv[0];
        pipe_stall_i   = ps[0];
        for (int s = 0; s < NUM_SLOTS; s++)
        begin
            rs1_i[s]             = arch_reg_t'(rs1_w[31 - 8*s -: 8]);
            rs2_i[s]             = arch_reg_t'(rs2_w[31 - 8*s -: 8]);
            rd_i[s]              = arch_reg_t'(rd_w[31 - 8*s -: 8]);
            write_rd_i[s]        = wr[3 - s];
            retire_free_i[s]     = phys_reg_t'(rel_w[31 - 8*s -: 8]);
            retire_free_vld_i[s] = rv[3 - s];
        end
        // sample just ahead of the rising edge
        #(CLK_PERIOD * 2 / 5);
        check_value("rename_stall_o", exp_stall, 32'(rename_stall_o));
        check_value("out_valid_o", exp_valid, 32'(out_valid_o));
        if (exp_valid[0])
        begin
            check_value("prs1_o", exp_prs1, pack_slots(prs1_o));
            check_value("prs2_o", exp_prs2, pack_slots(prs2_o));
            check_value("prd_o", exp_prd, pack_slots(prd_o));
            check_value("old_prd_o", exp_old, pack_slots(old_prd_o));
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence

    initial
    begin
        int    fd;
        string line;
        reset_n        = 1'b0;
        bundle_valid_i = 1'b0;
        pipe_stall_i   = 1'b0;
        num_vec        = 0;
        for (int s = 0; s < NUM_SLOTS; s++)
        begin
            rs1_i[s]             = '0;
            rs2_i[s]             = '0;
            rd_i[s]              = '0;
            write_rd_i[s]        = 1'b0;
            retire_free_i[s]     = '0;
            retire_free_vld_i[s] = 1'b0;
        end
        fd = $fopen("dv/rename_vectors.txt", "r");
        if (fd == 0)
        begin
            $display("the vector file could not be opened");
            $display("SIMULATION FAILED");
            $fatal(1);
        end
        while ($fgets(line, fd) != 0)
        begin
            if (line.len() > 1 && line.getc(0) != 8'h23)
                vec_q.push_back(line);
        end
        $fclose(fd);
        num_vec = vec_q.size();
        repeat (RST_CYCLES) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;
        foreach (vec_q[i])
        begin
            @(negedge clock);
            run_line(vec_q[i]);
        end
        $display("SIMULATION PASSED");
        $finish;
    end

    // watchdog sized from the vector count
    initial
    begin
        wait (num_vec > 0);
        repeat (num_vec + RST_CYCLES + 10) @(posedge clock);
        $display("the run did not finish in time");
        $display("SIMULATION FAILED");
        $fatal(1);
    end

endmodule

/* dv/rename_vectors.txt */
# bv wr rs1 rs2 rd pipe_stall rel_vld rel | rename_stall out_valid prs1 prs2 prd old_prd
# wr and rel_vld are binary slot masks; per-slot fields are 8 hex digits, slot 0 leftmost
# rename_stall is for this line's bundle, the other expected columns for the line before
0 0000 00000000 00000000 00000000 0 0000 00000000 0 0 00000000 00000000 00000000 00000000
1 1111 01020304 05060708 0a0b0c0d 0 0000 00000000 0 0 00000000 00000000 00000000 00000000
1 1101 01050505 020a0606 05050606 0 0000 00000000 0 1 01020304 05060708 20212223 0a0b0c0d
1 1010 050a0c07 060b0d0e 0a070e01 0 0000 00000000 0 1 01242525 02200606 24252626 05240606
1 1111 0a020304 0e030205 02030402 1 0000 00000000 0 1 25272207 26212328 27282829 20070e01
1 1111 0a020304 0e030205 02030402 1 0000 00000000 0 1 25272207 26212328 27282829 20070e01
1 1111 0a020304 0e030205 02030402 0 0000 00000000 0 1 25272207 26212328 27282829 20070e01
1 1111 00000000 00000000 10111213 0 0000 00000000 0 1 27292a2b 28032925 292a2b2c 02030429
1 1111 00000000 00000000 10111213 0 0000 00000000 0 1 00000000 00000000 2d2e2f30 10111213
1 1111 00000000 00000000 10111213 0 0000 00000000 0 1 00000000 00000000 31323334 2d2e2f30
1 1111 00000000 00000000 10111213 0 0000 00000000 0 1 00000000 00000000 35363738 31323334
1 1111 00000000 00000000 10111213 0 0000 00000000 0 1 00000000 00000000 393a3b3c 35363738
1 1111 00000000 00000000 10111213 0 0000 00000000 0 1 00000000 00000000 3d3e3f40 393a3b3c
1 1111 00000000 00000000 10111213 0 0000 00000000 0 1 00000000 00000000 41424344 3d3e3f40
1 1111 00000000 00000000 10111213 0 0000 00000000 0 1 00000000 00000000 45464748 41424344
1 1110 00000000 00000000 10111213 0 0000 00000000 0 1 00000000 00000000 494a4b4c 45464748
1 1111 10111213 00000000 14151617 0 0000 00000000 1 1 00000000 00000000 4d4e4f20 494a4b4c
1 1111 10111213 00000000 14151617 0 1111 0a0b0c0d 1 0 00000000 00000000 00000000 00000000
1 1111 10111213 00000000 14151617 0 0000 00000000 0 0 00000000 00000000 00000000 00000000
0 0000 00000000 00000000 00000000 0 0000 00000000 0 1 4d4e4f4c 00000000 0a0b0c0d 14151617
0 0000 00000000 00000000 00000000 0 0000 00000000 0 0 00000000 00000000 00000000 00000000

/* project.f */
verilog/rename_pkg.sv
verilog/rename_stage_if.sv
verilog/spec_rat.sv
verilog/free_list.sv
verilog/dep_check.sv
verilog/bundle_override.sv
verilog/rename_top.sv
dv/rename_checker.sv
dv/tb_rename.sv

/* run.sh */
#!/bin/sh
# build and run the rename stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_rename -f project.f -o sim_rename \
    && ./obj_dir/sim_rename | grep "SIMULATION PASSED" \
    && echo "rename run ok" \
    || { echo "rename run not ok"; exit 1; }
